// File: common/qla_pkg.sv
// --------------------
// shared constants and types for the current-command path
// DAC_SCLK_HALF must be at least 1, frame layout assumes 4 channels
// --------------------
package qla_pkg;

    localparam int NUM_CHANNELS = 4;     // motor axes
    localparam int CMD_WIDTH    = 16;    // command / feedback sample
    localparam int ADDR_WIDTH   = 16;
    localparam int DATA_WIDTH   = 32;

    // --------------------
    // register map
    localparam logic [3:0] ADDR_MAIN        = 4'h0;  // addr[15:12], board area
    localparam logic [3:0] OFF_AMP_ENABLE   = 4'h0;  // chan 0 only, global reg
    localparam logic [3:0] OFF_DAC_CTRL     = 4'h1;  // commanded current
    localparam logic [3:0] OFF_MOTOR_STATUS = 4'hC;  // amp enable + command

    localparam logic [CMD_WIDTH-1:0] MIDSCALE = 16'h8000;  // zero current, offset binary

    // --------------------
    // quad DAC framing
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'h3;  // write input reg and update
    localparam int DAC_FRAME_BITS = 24;    // cmd + addr + data
    localparam int DAC_SCLK_HALF  = 2;     // sysclk cycles per sclk half period
    localparam int DAC_BIT_CNT_W  = $clog2(DAC_FRAME_BITS + 1);
    localparam int DAC_HALF_CNT_W = $clog2(DAC_SCLK_HALF + 1);

    // --------------------
    // overcurrent check
    localparam int SAFETY_HOLD  = 8;       // cycles over limit before trip
    localparam int SAFETY_CNT_W = $clog2(SAFETY_HOLD + 1);
    localparam logic [CMD_WIDTH-1:0] SAFETY_MARGIN = 16'd256;  // fixed feedback allowance

    // channels 1..4 held as 0..3
    typedef logic [1:0] chan_t;

    typedef enum logic [2:0] {
        IDLE,   // wait for update pulse
        LOAD,   // build frame for current channel
        SHIFT,  // clock out 24 bits
        GAP,    // csel high between frames
        DONE    // drop busy
    } dac_state_e;

endpackage

// File: common/reg_bus_if.sv
// --------------------
// host register bus, read data one cycle after raddr
// --------------------
`timescale 1ns/100ps

interface reg_bus_if;

    logic                            wen;      // quadlet write strobe
    logic                            blk_wen;  // marks write as end of block
    logic [qla_pkg::ADDR_WIDTH-1:0]  waddr;
    logic [qla_pkg::DATA_WIDTH-1:0]  wdata;
    logic [qla_pkg::ADDR_WIDTH-1:0]  raddr;
    logic [qla_pkg::DATA_WIDTH-1:0]  rdata;    // registered in channel_regs

    // top side
    modport host (
        output wen, blk_wen, waddr, wdata, raddr,
        input  rdata
    );

    // register block side
    modport regs (
        input  wen, blk_wen, waddr, wdata, raddr,
        output rdata
    );

endinterface

// File: dac/dac_sequencer.sv
// --------------------
// frames one four-channel quad DAC update, busy until the last frame ends
// --------------------
`timescale 1ns/100ps

// control lines between the FSM and the serial pin driver
interface dac_link;

    logic                                load;      // capture frame
    logic [qla_pkg::DAC_FRAME_BITS-1:0]  frame;
    logic                                tick;      // sclk edge strobe
    logic                                last;      // final falling edge
    logic                                shift_en;  // frame in progress

    modport master (output load, frame, shift_en, input tick, last);
    modport slave  (input load, frame, shift_en, tick);

endinterface

module dac_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [qla_pkg::CMD_WIDTH-1:0]  cur_cmd [qla_pkg::NUM_CHANNELS],
    input  logic                           update,
    output logic                           dac_busy,
    output logic                           dac_sclk,
    output logic                           dac_mosi,
    output logic                           dac_csel
);

    qla_pkg::dac_state_e            state;
    qla_pkg::chan_t                 chan;   // channel being sent
    logic [qla_pkg::CMD_WIDTH-1:0]  snap [qla_pkg::NUM_CHANNELS];

    dac_link link ();

    assign link.load     = (state == qla_pkg::LOAD);
    assign link.shift_en = (state == qla_pkg::SHIFT);
    // cmd nibble, addr nibble (chan-1), 16-bit code
    assign link.frame    = {qla_pkg::DAC_CMD_WRITE_UPDATE, 2'b00, chan, snap[chan]};

    dac_bit_timer i_bit_timer (
        .clk  (clk),
        .rst  (rst),
        .run  (link.shift_en),
        .tick (link.tick),
        .last (link.last)
    );

    dac_shifter i_shifter (
        .clk      (clk),
        .rst      (rst),
        .link     (link),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi),
        .dac_csel (dac_csel)
    );

    // --------------------
    // update FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= qla_pkg::IDLE;
            chan     <= '0;
            dac_busy <= 1'b0;
        end else begin
            case (state)
                qla_pkg::IDLE: if (update) begin
                    chan     <= '0;
                    dac_busy <= 1'b1;
                    state    <= qla_pkg::LOAD;
                end
                qla_pkg::LOAD:  state <= qla_pkg::SHIFT;
                qla_pkg::SHIFT: if (link.last) state <= qla_pkg::GAP;
                qla_pkg::GAP: begin  // GAP + LOAD keep csel high 2 cycles
                    if (chan == qla_pkg::chan_t'(qla_pkg::NUM_CHANNELS - 1)) begin
                        state <= qla_pkg::DONE;
                    end else begin
                        chan  <= chan + 1'b1;
                        state <= qla_pkg::LOAD;
                    end
                end
                qla_pkg::DONE: begin
                    dac_busy <= 1'b0;  // pending request served next cycle
                    state    <= qla_pkg::IDLE;
                end
                default: state <= qla_pkg::IDLE;
            endcase
        end
    end

    // commands frozen for the whole update
    always_ff @(posedge clk) begin
        if (state == qla_pkg::IDLE && update) begin
            for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
                snap[i] <= cur_cmd[i];
            end
        end
    end

endmodule

// File: dac/dac_bit_timer.sv
// --------------------
// sclk phase and bit counter, cleared whenever run is low
// --------------------
`timescale 1ns/100ps

module dac_bit_timer (
    input  logic clk,
    input  logic rst,
    input  logic run,   // frame in progress
    output logic tick,  // one cycle before each sclk edge
    output logic last   // final falling edge of frame
);

    logic [qla_pkg::DAC_HALF_CNT_W-1:0] half_cnt;
    logic                               phase;    // 0 sclk low, 1 sclk high
    logic [qla_pkg::DAC_BIT_CNT_W-1:0]  bit_cnt;  // rising edges so far

    assign tick = run && (half_cnt == qla_pkg::DAC_HALF_CNT_W'(qla_pkg::DAC_SCLK_HALF - 1));
    assign last = tick && phase
                  && (bit_cnt == qla_pkg::DAC_BIT_CNT_W'(qla_pkg::DAC_FRAME_BITS));

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            half_cnt <= '0;
            phase    <= 1'b0;
            bit_cnt  <= '0;
        end else if (tick) begin
            half_cnt <= '0;
            phase    <= ~phase;
            if (!phase) begin
                bit_cnt <= bit_cnt + 1'b1;  // rising edge
            end
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

// File: dac/dac_shifter.sv
// --------------------
// MSB first, mosi changes on falling sclk
// --------------------
`timescale 1ns/100ps

module dac_shifter (
    input  logic   clk,
    input  logic   rst,
    dac_link.slave link,
    output logic   dac_sclk,
    output logic   dac_mosi,
    output logic   dac_csel
);

    logic [qla_pkg::DAC_FRAME_BITS-1:0] sreg;  // frame being shifted out

    assign dac_mosi = sreg[qla_pkg::DAC_FRAME_BITS-1];
    assign dac_csel = ~link.shift_en;  // active low

    // sclk follows the timer phase, idles low
    always_ff @(posedge clk) begin
        if (rst || !link.shift_en) begin
            dac_sclk <= 1'b0;
        end else if (link.tick) begin
            dac_sclk <= ~dac_sclk;
        end
    end

    always_ff @(posedge clk) begin
        if (link.load) begin
            sreg <= link.frame;
        end else if (link.shift_en && link.tick && dac_sclk) begin  // falling edge
            sreg <= {sreg[qla_pkg::DAC_FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

// File: logic/channel_regs.sv
// --------------------
// per-channel command regs, one pending DAC update at most
// addr bits 11..8 are not decoded
// --------------------
`timescale 1ns/100ps

module channel_regs (
    input  logic                            clk,
    input  logic                            rst,
    reg_bus_if.regs                         bus,
    input  logic                            dac_busy,
    input  logic [qla_pkg::NUM_CHANNELS-1:0] amp_disable,
    output logic [qla_pkg::CMD_WIDTH-1:0]   cur_cmd [qla_pkg::NUM_CHANNELS],
    output logic                            update,
    output logic [qla_pkg::NUM_CHANNELS-1:0] clear_disable
);

    // write side decode
    logic [3:0]                        w_chan;     // addr[7:4], 1..4 valid
    logic [3:0]                        w_chan_m1;
    qla_pkg::chan_t                    w_idx;
    logic                              w_main;
    logic                              wr_cmd;
    logic                              wr_amp;
    logic                              cmd_req;    // pending update
    logic [qla_pkg::NUM_CHANNELS-1:0]  amp_mask;   // last written enable mask
    // read side decode
    logic [3:0]                        r_chan;
    logic [3:0]                        r_chan_m1;
    qla_pkg::chan_t                    r_idx;
    logic                              r_main;
    logic                              r_chan_ok;
    logic [qla_pkg::DATA_WIDTH-1:0]    rd_mux;

    assign w_chan    = bus.waddr[7:4];
    assign w_chan_m1 = w_chan - 4'd1;
    assign w_idx     = w_chan_m1[1:0];
    assign w_main    = (bus.waddr[15:12] == qla_pkg::ADDR_MAIN);
    assign wr_cmd    = bus.wen && w_main && (w_chan != 4'd0)
                       && (w_chan <= 4'(qla_pkg::NUM_CHANNELS))
                       && (bus.waddr[3:0] == qla_pkg::OFF_DAC_CTRL);
    assign wr_amp    = bus.wen && w_main && (w_chan == 4'd0)
                       && (bus.waddr[3:0] == qla_pkg::OFF_AMP_ENABLE);

    // fire as soon as the DAC is idle, busy rises the next cycle
    assign update = cmd_req && !dac_busy;

    // --------------------
    // write path
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_req       <= 1'b0;
            amp_mask      <= '0;
            clear_disable <= '0;
            for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
                cur_cmd[i] <= qla_pkg::MIDSCALE;
            end
        end else begin
            clear_disable <= '0;  // single-cycle pulse
            if (wr_cmd) begin
                cur_cmd[w_idx] <= bus.wdata[qla_pkg::CMD_WIDTH-1:0];
            end
            if (wr_cmd && bus.blk_wen) begin
                cmd_req <= 1'b1;  // later block writes merge here
            end else if (update) begin
                cmd_req <= 1'b0;
            end
            if (wr_amp) begin
                amp_mask      <= bus.wdata[qla_pkg::NUM_CHANNELS-1:0];
                clear_disable <= bus.wdata[qla_pkg::NUM_CHANNELS-1:0];
            end
        end
    end

    // --------------------
    // read path
    assign r_chan    = bus.raddr[7:4];
    assign r_chan_m1 = r_chan - 4'd1;
    assign r_idx     = r_chan_m1[1:0];
    assign r_main    = (bus.raddr[15:12] == qla_pkg::ADDR_MAIN);
    assign r_chan_ok = (r_chan != 4'd0) && (r_chan <= 4'(qla_pkg::NUM_CHANNELS));

    always_comb begin
        rd_mux = '0;
        if (r_main && r_chan_ok) begin
            case (bus.raddr[3:0])
                qla_pkg::OFF_DAC_CTRL:
                    rd_mux = {{(qla_pkg::DATA_WIDTH - qla_pkg::CMD_WIDTH){1'b0}}, cur_cmd[r_idx]};
                qla_pkg::OFF_MOTOR_STATUS:  // bit 28 = amp enabled
                    rd_mux = {3'b000, ~amp_disable[r_idx], 12'd0, cur_cmd[r_idx]};
                default:
                    rd_mux = '0;
            endcase
        end else if (r_main && (r_chan == 4'd0) && (bus.raddr[3:0] == qla_pkg::OFF_AMP_ENABLE)) begin
            rd_mux = {{(qla_pkg::DATA_WIDTH - qla_pkg::NUM_CHANNELS){1'b0}}, amp_mask};
        end
    end

    always_ff @(posedge clk) begin
        bus.rdata <= rd_mux;  // valid one cycle after raddr
    end

endmodule

// File: logic/safety_check.sv
// --------------------
// trips when |fb| > 2*|cmd| + margin for SAFETY_HOLD+1 cycles
// --------------------
`timescale 1ns/100ps

module safety_check (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [qla_pkg::CMD_WIDTH-1:0]    cur_fb [qla_pkg::NUM_CHANNELS],
    input  logic [qla_pkg::CMD_WIDTH-1:0]    cur_cmd [qla_pkg::NUM_CHANNELS],
    input  logic [qla_pkg::NUM_CHANNELS-1:0] clear_disable,
    output logic [qla_pkg::NUM_CHANNELS-1:0] amp_disable
);

    logic [qla_pkg::CMD_WIDTH-1:0]    fb_mag [qla_pkg::NUM_CHANNELS];   // distance from midscale
    logic [qla_pkg::CMD_WIDTH-1:0]    cmd_mag [qla_pkg::NUM_CHANNELS];
    logic [qla_pkg::CMD_WIDTH+1:0]    limit [qla_pkg::NUM_CHANNELS];    // 2x plus margin, no overflow
    logic [qla_pkg::NUM_CHANNELS-1:0] over;
    logic [qla_pkg::SAFETY_CNT_W-1:0] hold_cnt [qla_pkg::NUM_CHANNELS]; // saturates at SAFETY_HOLD

    // offset binary, msb set means positive side
    always_comb begin
        for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
            fb_mag[i]  = cur_fb[i][qla_pkg::CMD_WIDTH-1] ? cur_fb[i] - qla_pkg::MIDSCALE
                                                        : qla_pkg::MIDSCALE - cur_fb[i];
            cmd_mag[i] = cur_cmd[i][qla_pkg::CMD_WIDTH-1] ? cur_cmd[i] - qla_pkg::MIDSCALE
                                                          : qla_pkg::MIDSCALE - cur_cmd[i];
            limit[i]   = {1'b0, cmd_mag[i], 1'b0} + {2'b00, qla_pkg::SAFETY_MARGIN};
            over[i]    = {2'b00, fb_mag[i]} > limit[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            amp_disable <= '0;
            for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
                if (clear_disable[i]) begin  // host re-enable wins
                    hold_cnt[i]    <= '0;
                    amp_disable[i] <= 1'b0;
                end else if (!over[i]) begin
                    hold_cnt[i] <= '0;       // must be consecutive
                end else if (hold_cnt[i] == qla_pkg::SAFETY_CNT_W'(qla_pkg::SAFETY_HOLD)) begin
                    amp_disable[i] <= 1'b1;  // latched until cleared
                end else begin
                    hold_cnt[i] <= hold_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

// File: logic/motor_ctrl_top.sv
// --------------------
// current-command path top, feedback arrives as plain ports
// --------------------
`timescale 1ns/100ps

module motor_ctrl_top (
    input  logic                             clk,
    input  logic                             rst,
    // host register bus
    input  logic                             reg_wen,
    input  logic                             reg_blk_wen,
    input  logic [qla_pkg::ADDR_WIDTH-1:0]   reg_waddr,
    input  logic [qla_pkg::DATA_WIDTH-1:0]   reg_wdata,
    input  logic [qla_pkg::ADDR_WIDTH-1:0]   reg_raddr,
    output logic [qla_pkg::DATA_WIDTH-1:0]   reg_rdata,
    // measured current, offset binary
    input  logic [qla_pkg::CMD_WIDTH-1:0]    cur_fb [qla_pkg::NUM_CHANNELS],
    // quad DAC pins and status
    output logic                             dac_sclk,
    output logic                             dac_mosi,
    output logic                             dac_csel,
    output logic                             dac_busy,
    output logic [qla_pkg::NUM_CHANNELS-1:0] amp_disable
);

    logic [qla_pkg::CMD_WIDTH-1:0]    cur_cmd [qla_pkg::NUM_CHANNELS];
    logic                             update;         // start DAC update
    logic [qla_pkg::NUM_CHANNELS-1:0] clear_disable;  // from amp-enable write

    reg_bus_if bus ();

    // --------------------
    // bundle the host bus
    assign bus.wen     = reg_wen;
    assign bus.blk_wen = reg_blk_wen;
    assign bus.waddr   = reg_waddr;
    assign bus.wdata   = reg_wdata;
    assign bus.raddr   = reg_raddr;
    assign reg_rdata   = bus.rdata;

    channel_regs i_channel_regs (
        .clk           (clk),
        .rst           (rst),
        .bus           (bus),
        .dac_busy      (dac_busy),
        .amp_disable   (amp_disable),
        .cur_cmd       (cur_cmd),
        .update        (update),
        .clear_disable (clear_disable)
    );

    safety_check i_safety_check (
        .clk           (clk),
        .rst           (rst),
        .cur_fb        (cur_fb),
        .cur_cmd       (cur_cmd),
        .clear_disable (clear_disable),
        .amp_disable   (amp_disable)
    );

    dac_sequencer i_dac_sequencer (
        .clk      (clk),
        .rst      (rst),
        .cur_cmd  (cur_cmd),
        .update   (update),
        .dac_busy (dac_busy),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi),
        .dac_csel (dac_csel)
    );

endmodule

// File: verification/motor_ctrl_ref.svh
// --------------------
// expected frames, reads and trips, built on the testbench model state
// --------------------
`ifndef MOTOR_CTRL_REF_SVH
`define MOTOR_CTRL_REF_SVH

// cmd nibble, channel-1 nibble, 16-bit code, MSB first on the wire
function automatic logic [qla_pkg::DAC_FRAME_BITS-1:0] ref_frame(input int chan,
                                                                 input logic [15:0] cmd);
    return {qla_pkg::DAC_CMD_WRITE_UPDATE, 4'(chan - 1), cmd};
endfunction

// distance from zero current, offset binary
function automatic int ref_mag(input logic [15:0] v);
    int d;
    d = int'(v) - int'(qla_pkg::MIDSCALE);
    return (d < 0) ? -d : d;
endfunction

function automatic logic ref_trips(input logic [15:0] fb, input logic [15:0] cmd);
    return ref_mag(fb) > 2 * ref_mag(cmd) + int'(qla_pkg::SAFETY_MARGIN);
endfunction

// register read map
function automatic logic [31:0] ref_read(input int chan, input logic [3:0] off);
    logic [31:0] status;
    if (chan >= 1 && chan <= qla_pkg::NUM_CHANNELS) begin
        if (off == qla_pkg::OFF_DAC_CTRL) begin
            return {16'h0, model_cmd[chan-1]};
        end
        if (off == qla_pkg::OFF_MOTOR_STATUS) begin
            status     = {16'h0, model_cmd[chan-1]};
            status[28] = !model_dis[chan-1];  // amplifier enabled
            return status;
        end
    end else if (chan == 0 && off == qla_pkg::OFF_AMP_ENABLE) begin
        return {28'h0, model_mask};
    end
    return 32'h0;
endfunction

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
endtask

`endif

// File: verification/motor_ctrl_tb.sv
// --------------------
// register, DAC frame and overcurrent checks against a reference model
// --------------------
`timescale 1ns/100ps

module motor_ctrl_tb;

    localparam int CLK_HALF       = 20;  // 40 ns period
    localparam int FRAME_CYCLES   = qla_pkg::DAC_FRAME_BITS * 2 * qla_pkg::DAC_SCLK_HALF + 2;
    localparam int NUM_UPDATES    = 3;
    localparam int SETUP_CYCLES   = 800;  // reset, register traffic, settle waits
    localparam int TIMEOUT_CYCLES = 2 * (NUM_UPDATES * 4 * FRAME_CYCLES + SETUP_CYCLES);

    logic                             clk;
    logic                             rst;
    logic                             reg_wen;
    logic                             reg_blk_wen;
    logic [qla_pkg::ADDR_WIDTH-1:0]   reg_waddr;
    logic [qla_pkg::DATA_WIDTH-1:0]   reg_wdata;
    logic [qla_pkg::ADDR_WIDTH-1:0]   reg_raddr;
    logic [qla_pkg::DATA_WIDTH-1:0]   reg_rdata;
    logic [qla_pkg::CMD_WIDTH-1:0]    cur_fb [qla_pkg::NUM_CHANNELS];
    logic                             dac_sclk;
    logic                             dac_mosi;
    logic                             dac_csel;
    logic                             dac_busy;
    logic [qla_pkg::NUM_CHANNELS-1:0] amp_disable;

    // model of the register state
    logic [qla_pkg::CMD_WIDTH-1:0]    model_cmd [qla_pkg::NUM_CHANNELS];
    logic [qla_pkg::NUM_CHANNELS-1:0] model_dis;
    logic [qla_pkg::NUM_CHANNELS-1:0] model_mask;
    int seed = 68;
    int errors = 0;
    int checks = 0;
    // frame capture and compare
    logic [qla_pkg::DAC_FRAME_BITS-1:0] got_q [$];
    logic [qla_pkg::DAC_FRAME_BITS-1:0] exp_q [$];
    logic [qla_pkg::DAC_FRAME_BITS-1:0] shift_frame;
    int nbits = 0;
    int frames_rx = 0;   // captured
    int frames_cmp = 0;  // compared
    int frames_exp = 0;  // queued by stimulus

    `include "motor_ctrl_ref.svh"

    motor_ctrl_top i_motor_ctrl_top (
        .clk         (clk),
        .rst         (rst),
        .reg_wen     (reg_wen),
        .reg_blk_wen (reg_blk_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .reg_rdata   (reg_rdata),
        .cur_fb      (cur_fb),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel),
        .dac_busy    (dac_busy),
        .amp_disable (amp_disable)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_HALF) clk = ~clk;
        end
    end

    // --------------------
    // receiver side, samples on rising sclk while csel low
    always @(posedge dac_sclk or posedge dac_csel) begin
        if (dac_csel) begin
            if (nbits != 0) begin
                errors++;
                $display("DAC frame cut short after %0d bits at %0t", nbits, $time);
            end
            nbits = 0;
        end else begin
            shift_frame = {shift_frame[qla_pkg::DAC_FRAME_BITS-2:0], dac_mosi};
            nbits++;
            if (nbits == qla_pkg::DAC_FRAME_BITS) begin
                got_q.push_back(shift_frame);
                frames_rx++;
                nbits = 0;
            end
        end
    end

    initial begin : compare_frames
        logic [qla_pkg::DAC_FRAME_BITS-1:0] got;
        forever begin
            wait (frames_rx > frames_cmp);
            got = got_q.pop_front();
            frames_cmp++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("DAC frame %h sent with no update pending at %0t", got, $time);
            end else begin
                check_equal(32'(got), 32'(exp_q.pop_front()), "DAC frame");
            end
        end
    end

    // --------------------
    // bus helpers
    function automatic logic [15:0] addr_of(input int chan, input logic [3:0] off);
        return {qla_pkg::ADDR_MAIN, 4'h0, 4'(chan), off};  // bits 11..8 unused
    endfunction

    task automatic write_reg(input int chan, input logic [3:0] off,
                             input logic [31:0] data, input logic blk);
        @(posedge clk);
        reg_wen     <= 1'b1;
        reg_blk_wen <= blk;
        reg_waddr   <= addr_of(chan, off);
        reg_wdata   <= data;
        @(posedge clk);
        reg_wen     <= 1'b0;
        reg_blk_wen <= 1'b0;
        if (off == qla_pkg::OFF_DAC_CTRL && chan >= 1 && chan <= qla_pkg::NUM_CHANNELS) begin
            model_cmd[chan-1] = data[qla_pkg::CMD_WIDTH-1:0];
        end
        if (off == qla_pkg::OFF_AMP_ENABLE && chan == 0) begin
            model_mask = data[qla_pkg::NUM_CHANNELS-1:0];
            model_dis  = model_dis & ~data[qla_pkg::NUM_CHANNELS-1:0];  // re-enable
        end
    endtask

    task automatic read_check(input int chan, input logic [3:0] off);
        @(posedge clk);
        reg_raddr <= addr_of(chan, off);
        @(posedge clk);
        @(negedge clk);  // rdata one cycle after raddr
        check_equal(reg_rdata, ref_read(chan, off), $sformatf("read ch%0d off %h", chan, off));
    endtask

    task automatic queue_update_frames();
        for (int c = 1; c <= qla_pkg::NUM_CHANNELS; c++) begin
            exp_q.push_back(ref_frame(c, model_cmd[c-1]));
        end
        frames_exp += qla_pkg::NUM_CHANNELS;
    endtask

    task automatic wait_update_done();
        wait (dac_busy);
        wait (!dac_busy);
    endtask

    // --------------------
    // stimulus
    initial begin : stimulus
        logic [qla_pkg::CMD_WIDTH-1:0]    fb_val [qla_pkg::NUM_CHANNELS];
        logic [qla_pkg::NUM_CHANNELS-1:0] trip_exp;
        rst         <= 1'b1;
        reg_wen     <= 1'b0;
        reg_blk_wen <= 1'b0;
        reg_waddr   <= '0;
        reg_wdata   <= '0;
        reg_raddr   <= '0;
        model_dis   = '0;
        model_mask  = '0;
        for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
            cur_fb[i]    <= qla_pkg::MIDSCALE;
            model_cmd[i] = qla_pkg::MIDSCALE;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset state
        for (int c = 1; c <= 4; c++) read_check(c, qla_pkg::OFF_DAC_CTRL);
        check_equal(dac_csel, 1'b1, "csel idle after reset");
        check_equal(dac_sclk, 1'b0, "sclk idle after reset");
        check_equal(dac_busy, 1'b0, "busy clear after reset");
        check_equal(amp_disable, '0, "amp_disable after reset");

        // plain writes, channel 0 and 5 ignored
        for (int c = 1; c <= 4; c++) write_reg(c, qla_pkg::OFF_DAC_CTRL, $random(seed), 1'b0);
        write_reg(0, qla_pkg::OFF_DAC_CTRL, $random(seed), 1'b0);
        write_reg(5, qla_pkg::OFF_DAC_CTRL, $random(seed), 1'b0);
        for (int c = 0; c <= 5; c++) read_check(c, qla_pkg::OFF_DAC_CTRL);

        // single block write update
        for (int c = 1; c <= 4; c++) write_reg(c, qla_pkg::OFF_DAC_CTRL, $random(seed), c == 4);
        queue_update_frames();
        wait_update_done();
        repeat (FRAME_CYCLES) @(posedge clk);
        @(negedge clk);
        check_equal(frames_rx, frames_exp, "frame count after block write");

        // block writes during busy merge into one pending update
        for (int c = 1; c <= 4; c++) write_reg(c, qla_pkg::OFF_DAC_CTRL, $random(seed), c == 4);
        queue_update_frames();
        wait (dac_busy);
        write_reg(2, qla_pkg::OFF_DAC_CTRL, $random(seed), 1'b1);
        write_reg(3, qla_pkg::OFF_DAC_CTRL, $random(seed), 1'b0);
        write_reg(1, qla_pkg::OFF_DAC_CTRL, $random(seed), 1'b1);
        @(negedge clk);
        check_equal(dac_busy, 1'b1, "busy across merged writes");
        queue_update_frames();  // latest commands
        wait (!dac_busy);
        wait_update_done();
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        @(negedge clk);
        check_equal(frames_rx, frames_exp, "frame count after merged update");

        // overcurrent, ch1 and ch3 far over, ch2 right at its limit, ch4 one count past
        write_reg(1, qla_pkg::OFF_DAC_CTRL,
                  qla_pkg::MIDSCALE + (16'($random(seed)) & 16'h03FF), 1'b0);
        write_reg(2, qla_pkg::OFF_DAC_CTRL,
                  qla_pkg::MIDSCALE + (16'($random(seed)) & 16'h03FF), 1'b0);
        write_reg(3, qla_pkg::OFF_DAC_CTRL,
                  qla_pkg::MIDSCALE - (16'($random(seed)) & 16'h03FF), 1'b0);
        write_reg(4, qla_pkg::OFF_DAC_CTRL,
                  qla_pkg::MIDSCALE - (16'($random(seed)) & 16'h03FF), 1'b0);
        fb_val[0] = qla_pkg::MIDSCALE + 16'h4000 + (16'($random(seed)) & 16'h0FFF);
        fb_val[2] = qla_pkg::MIDSCALE - 16'h4000 - (16'($random(seed)) & 16'h0FFF);
        fb_val[1] = qla_pkg::MIDSCALE + 16'(2 * ref_mag(model_cmd[1]))
                    + qla_pkg::SAFETY_MARGIN;  // exactly at the limit
        fb_val[3] = qla_pkg::MIDSCALE - 16'(2 * ref_mag(model_cmd[3]))
                    - qla_pkg::SAFETY_MARGIN - 16'd1;  // just beyond, negative side
        for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) begin
            trip_exp[i] = ref_trips(fb_val[i], model_cmd[i]);
        end
        @(posedge clk);
        for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) cur_fb[i] <= fb_val[i];
        repeat (qla_pkg::SAFETY_HOLD) @(posedge clk);
        @(negedge clk);
        check_equal(amp_disable, model_dis, "no trip before hold time");
        @(posedge clk);
        @(negedge clk);
        check_equal(amp_disable, trip_exp, "trip after hold time");
        model_dis = trip_exp;
        repeat (3 * qla_pkg::SAFETY_HOLD) @(posedge clk);
        @(negedge clk);
        check_equal(amp_disable, model_dis, "within-limit channel stays enabled");
        for (int c = 1; c <= 4; c++) read_check(c, qla_pkg::OFF_MOTOR_STATUS);
        @(posedge clk);
        for (int i = 0; i < qla_pkg::NUM_CHANNELS; i++) cur_fb[i] <= qla_pkg::MIDSCALE;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_equal(amp_disable, model_dis, "disable latched after feedback drops");

        // amp-enable mask clears selected channels only
        write_reg(0, qla_pkg::OFF_AMP_ENABLE, 32'h1, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_equal(amp_disable, model_dis, "mask 1 clears channel 1");
        read_check(0, qla_pkg::OFF_AMP_ENABLE);
        for (int c = 1; c <= 4; c++) read_check(c, qla_pkg::OFF_MOTOR_STATUS);
        write_reg(0, qla_pkg::OFF_AMP_ENABLE, 32'h4, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_equal(amp_disable, model_dis, "mask 4 clears channel 3");
        read_check(0, qla_pkg::OFF_AMP_ENABLE);

        check_equal(exp_q.size(), 0, "expected frames never sent");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, DAC update or test sequence stalled", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: motor_ctrl_top.f
+incdir+verification
common/qla_pkg.sv
common/reg_bus_if.sv
dac/dac_sequencer.sv
dac/dac_bit_timer.sv
dac/dac_shifter.sv
logic/channel_regs.sv
logic/safety_check.sv
logic/motor_ctrl_top.sv
verification/motor_ctrl_tb.sv

// File: Bender.yml
package:
  name: motor_ctrl

sources:
  - files:
      - common/qla_pkg.sv
      - common/reg_bus_if.sv
      - dac/dac_sequencer.sv
      - dac/dac_bit_timer.sv
      - dac/dac_shifter.sv
      - logic/channel_regs.sv
      - logic/safety_check.sv
      - logic/motor_ctrl_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/motor_ctrl_tb.sv
